// File: logic/asn_pkg.sv
// shared constants and types of the rx speed negotiation controller
// rate and count words, state and counter enums, config/status/control structs
package asn_pkg;

	// **************************************************
	// constants
	// **************************************************
	localparam logic ASN_RST_DLL_LOCK_EN = 1'b1;	// dll lock enabled out of reset
	localparam int   SYNC_STAGES         = 2;	// flops per synchronizer

	typedef logic [1:0] asn_rate_t;	// pipe rate, 0 gen1 / 1 gen2 / 2 gen3
	typedef logic [7:0] asn_cnt_t;	// wait length in hclk cycles

	// negotiation sequence, encodings kept from the adapter
	typedef enum logic [3:0]
	{
		WAIT_RATE_CHANGE    = 4'd0,
		HOLD_FIFO_DATA      = 4'd1,
		RESET_DLL           = 4'd2,
		WAIT_DLL_RESET      = 4'd3,
		WAIT_SWITCH_REQUEST = 4'd4,
		WAIT_SWITCH_DONE    = 4'd5,
		ENABLE_DLL_LOCK     = 4'd6,
		WAIT_DLL_LOCK_DONE  = 4'd7,
		SPEED_CHANGE_DONE   = 4'd8
	} asn_state_e;

	typedef enum logic [1:0]
	{
		CNT_NONE,		// counter held cleared
		CNT_FIFO_FLUSH,
		CNT_DLL_RESET,
		CNT_SW_DONE
	} asn_cnt_sel_e;

	// **************************************************
	// structs
	// **************************************************
	typedef struct packed
	{
		logic		asn_en;			// 0 parks the fsm in idle
		logic		bypass_sw_done;		// skip the sw_done change check
		logic		hrdrst_user_ctl_en;	// fabric drives data transfer enable
		asn_cnt_t	fifo_flush_cnt;
		asn_cnt_t	dll_reset_cnt;
		asn_cnt_t	sw_done_cnt;
	} asn_cfg_t;

	typedef struct packed
	{
		logic [1:0]	master_sel;		// 00/11 local, 01 up, 10 down
		logic		dist_master_sel;	// this lane drives the chain
		logic		dft_in_en;
		logic		dft_in_value;
	} bond_cfg_t;

	typedef struct packed
	{
		logic		sw_done_changed;
		logic		mask_tx_pll;
		logic		data_transfer_en;
		logic		phystatus_rise;
	} asn_status_t;

	typedef struct packed
	{
		logic		fifo_hold;
		logic		dll_lock_en;
		logic		wait_sw_done;		// arms sw_done change memory
		logic		wait_phystatus;		// arms phystatus rise memory
	} asn_ctrl_t;

endpackage

// File: logic/asn_bitsync.sv
// parameterized flop synchronizer for the hclk domain, resets to zero
module asn_bitsync
#(
	parameter int width = 1
)
(
	input	logic			rx_clock_asn_pma_hclk,
	input	logic			rx_reset_asn_pma_hclk_rst_n,
	input	logic [width-1:0]	data_in,
	output	logic [width-1:0]	data_out
);
	import asn_pkg::*;

	logic [SYNC_STAGES-1:0][width-1:0]	sync_q;	// stage 0 is the capture flop

	always_ff @(posedge rx_clock_asn_pma_hclk)
	begin
		if (!rx_reset_asn_pma_hclk_rst_n)
		begin
			sync_q <= '0;
		end
		else
		begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], data_in};	// shift toward output
		end
	end

	assign data_out = sync_q[SYNC_STAGES-1];

endmodule

// File: logic/asn_rate_detect.sv
// requested rate sync, stability filter, committed rate and change pulse
module asn_rate_detect
(
	input	logic			rx_clock_asn_pma_hclk,
	input	logic			rx_reset_asn_pma_hclk_rst_n,
	input	asn_pkg::asn_rate_t	rx_pld_rate,
	input	logic			idle,
	output	logic			rate_change_pulse
);
	import asn_pkg::*;

	asn_rate_t	rate_sync;
	asn_rate_t	rate_q1;
	asn_rate_t	rate_q2;
	asn_rate_t	rate_held;	// last rate acted on
	logic		allow_update;

	asn_bitsync #(.width($bits(asn_rate_t))) u_rate_sync
	(
		.rx_clock_asn_pma_hclk		(rx_clock_asn_pma_hclk),
		.rx_reset_asn_pma_hclk_rst_n	(rx_reset_asn_pma_hclk_rst_n),
		.data_in			(rx_pld_rate),
		.data_out			(rate_sync)
	);

	// two more samples for the stability window
	always_ff @(posedge rx_clock_asn_pma_hclk)
	begin
		if (!rx_reset_asn_pma_hclk_rst_n)
		begin
			rate_q1 <= '0;
			rate_q2 <= '0;
		end
		else
		begin
			rate_q1 <= rate_sync;
			rate_q2 <= rate_q1;
		end
	end

	// three equal samples and fsm idle
	assign allow_update = idle && (rate_sync == rate_q1) && (rate_q1 == rate_q2);

	always_ff @(posedge rx_clock_asn_pma_hclk)
	begin
		if (!rx_reset_asn_pma_hclk_rst_n)
			rate_held <= '0;	// gen1 out of reset
		else if (allow_update)
			rate_held <= rate_q2;
	end

	assign rate_change_pulse = allow_update && (rate_held != rate_q2);	// one cycle only

endmodule

// File: logic/asn_pma_status.sv
// pma/pcs status synchronizers, data transfer enable source select,
// sw_done change memory and phystatus rise memory
module asn_pma_status
(
	input	logic			rx_clock_asn_pma_hclk,
	input	logic			rx_reset_asn_pma_hclk_rst_n,
	input	logic [1:0]		rx_ssr_pcie_sw_done,
	input	logic			rx_fsr_mask_tx_pll,
	input	logic			rx_hrdrst_asn_data_transfer_en,
	input	logic			pld_fabric_rx_asn_data_transfer_en,
	input	logic			rx_asn_phystatus,
	input	logic			hrdrst_user_ctl_en,
	input	asn_pkg::asn_ctrl_t	ctrl,
	output	asn_pkg::asn_status_t	status
);

	logic [1:0]	sw_done_sync;
	logic [1:0]	sw_done_q;	// previous synced sw_done
	logic		mask_sync;
	logic		dte_sel;	// chosen data transfer enable source
	logic		dte_sync;
	logic		phystatus_sync;
	logic		phystatus_q;
	logic		sw_done_mem;
	logic		phystatus_mem;

	assign dte_sel = hrdrst_user_ctl_en ? pld_fabric_rx_asn_data_transfer_en
					    : rx_hrdrst_asn_data_transfer_en;

	// **************************************************
	// synchronizers
	// **************************************************
	asn_bitsync #(.width(2)) u_sw_done_sync
	(
		.rx_clock_asn_pma_hclk		(rx_clock_asn_pma_hclk),
		.rx_reset_asn_pma_hclk_rst_n	(rx_reset_asn_pma_hclk_rst_n),
		.data_in			(rx_ssr_pcie_sw_done),
		.data_out			(sw_done_sync)
	);

	asn_bitsync #(.width(1)) u_mask_sync
	(
		.rx_clock_asn_pma_hclk		(rx_clock_asn_pma_hclk),
		.rx_reset_asn_pma_hclk_rst_n	(rx_reset_asn_pma_hclk_rst_n),
		.data_in			(rx_fsr_mask_tx_pll),
		.data_out			(mask_sync)
	);

	asn_bitsync #(.width(1)) u_dte_sync
	(
		.rx_clock_asn_pma_hclk		(rx_clock_asn_pma_hclk),
		.rx_reset_asn_pma_hclk_rst_n	(rx_reset_asn_pma_hclk_rst_n),
		.data_in			(dte_sel),
		.data_out			(dte_sync)
	);

	asn_bitsync #(.width(1)) u_phystatus_sync
	(
		.rx_clock_asn_pma_hclk		(rx_clock_asn_pma_hclk),
		.rx_reset_asn_pma_hclk_rst_n	(rx_reset_asn_pma_hclk_rst_n),
		.data_in			(rx_asn_phystatus),
		.data_out			(phystatus_sync)
	);

	// **************************************************
	// event memories, cleared while not armed
	// **************************************************
	always_ff @(posedge rx_clock_asn_pma_hclk)
	begin
		if (!rx_reset_asn_pma_hclk_rst_n)
		begin
			sw_done_q     <= 2'b00;
			phystatus_q   <= 1'b0;
			sw_done_mem   <= 1'b0;
			phystatus_mem <= 1'b0;
		end
		else
		begin
			sw_done_q   <= sw_done_sync;
			phystatus_q <= phystatus_sync;
			// any toggle of either sw_done bit
			sw_done_mem <= ctrl.wait_sw_done &&
				       ((sw_done_q != sw_done_sync) || sw_done_mem);
			phystatus_mem <= ctrl.wait_phystatus &&
					 ((phystatus_sync && !phystatus_q) || phystatus_mem);
		end
	end

	assign status.sw_done_changed  = sw_done_mem;
	assign status.mask_tx_pll      = mask_sync;
	assign status.data_transfer_en = dte_sync;
	assign status.phystatus_rise   = phystatus_mem;

endmodule

// File: logic/asn_wait_counter.sv
// shared wait counter, threshold picked by the fsm's counter select
module asn_wait_counter
(
	input	logic			rx_clock_asn_pma_hclk,
	input	logic			rx_reset_asn_pma_hclk_rst_n,
	input	asn_pkg::asn_cnt_sel_e	cnt_sel,
	input	asn_pkg::asn_cfg_t	cfg,
	output	logic			cnt_done
);
	import asn_pkg::*;

	asn_cnt_t	cnt_q;
	asn_cnt_t	threshold;
	logic		done_q;	// sticky until cnt_sel returns to none

	always_comb
	begin
		unique case (cnt_sel)
			CNT_FIFO_FLUSH:	threshold = cfg.fifo_flush_cnt;
			CNT_DLL_RESET:	threshold = cfg.dll_reset_cnt;
			CNT_SW_DONE:	threshold = cfg.sw_done_cnt;
			default:	threshold = '0;	// none, counter idle
		endcase
	end

	always_ff @(posedge rx_clock_asn_pma_hclk)
	begin
		if (!rx_reset_asn_pma_hclk_rst_n || (cnt_sel == CNT_NONE))
		begin
			cnt_q  <= '0;
			done_q <= 1'b0;
		end
		else
		begin
			cnt_q <= cnt_q + 8'd1;	// free running within a wait
			if (!done_q)
				done_q <= (cnt_q == threshold);
		end
	end

	assign cnt_done = done_q;

endmodule

// File: logic/asn_ctrl_fsm.sv
// nine-state speed negotiation fsm with registered control outputs
module asn_ctrl_fsm
(
	input	logic			rx_clock_asn_pma_hclk,
	input	logic			rx_reset_asn_pma_hclk_rst_n,
	input	asn_pkg::asn_cfg_t	cfg,
	input	logic			rate_change_pulse,
	input	asn_pkg::asn_status_t	status,
	input	logic			cnt_done,
	output	logic			idle,
	output	asn_pkg::asn_cnt_sel_e	cnt_sel,
	output	asn_pkg::asn_ctrl_t	ctrl
);
	import asn_pkg::*;

	asn_state_e	state_q;
	asn_state_e	state_d;
	asn_ctrl_t	ctrl_d;	// decoded from state, registered below

	// **************************************************
	// state register
	// **************************************************
	always_ff @(posedge rx_clock_asn_pma_hclk)
	begin
		if (!rx_reset_asn_pma_hclk_rst_n || !cfg.asn_en)
			state_q <= WAIT_RATE_CHANGE;	// disabled lane parks here
		else
			state_q <= state_d;
	end

	// **************************************************
	// next state and output decode
	// **************************************************
	always_comb
	begin
		state_d            = state_q;
		cnt_sel            = CNT_NONE;
		ctrl_d.fifo_hold   = 1'b0;
		ctrl_d.dll_lock_en = 1'b1;
		ctrl_d.wait_sw_done   = 1'b0;
		ctrl_d.wait_phystatus = 1'b0;
		case (state_q)
			WAIT_RATE_CHANGE:
			begin
				if (rate_change_pulse)
					state_d = HOLD_FIFO_DATA;
			end
			HOLD_FIFO_DATA:
			begin
				ctrl_d.fifo_hold = 1'b1;
				cnt_sel          = CNT_FIFO_FLUSH;	// let the fifo drain
				if (cnt_done)
					state_d = RESET_DLL;
			end
			RESET_DLL, WAIT_DLL_RESET, WAIT_SWITCH_REQUEST, WAIT_SWITCH_DONE:
			begin
				ctrl_d.fifo_hold      = 1'b1;
				ctrl_d.dll_lock_en    = 1'b0;	// dll held in reset
				ctrl_d.wait_sw_done   = 1'b1;
				ctrl_d.wait_phystatus = 1'b1;
				if (state_q == RESET_DLL)
					state_d = WAIT_DLL_RESET;	// single cycle
				else if (state_q == WAIT_DLL_RESET)
				begin
					cnt_sel = CNT_DLL_RESET;
					if (cnt_done)
						state_d = WAIT_SWITCH_REQUEST;
				end
				else if (state_q == WAIT_SWITCH_REQUEST)
				begin
					if (status.mask_tx_pll)	// pma asks to switch
						state_d = WAIT_SWITCH_DONE;
				end
				else
				begin
					cnt_sel = CNT_SW_DONE;
					if (cnt_done && (status.sw_done_changed || cfg.bypass_sw_done))
						state_d = ENABLE_DLL_LOCK;
				end
			end
			ENABLE_DLL_LOCK:
			begin
				ctrl_d.fifo_hold      = 1'b1;
				ctrl_d.wait_phystatus = 1'b1;
				state_d               = WAIT_DLL_LOCK_DONE;	// single cycle
			end
			WAIT_DLL_LOCK_DONE:
			begin
				ctrl_d.fifo_hold      = 1'b1;
				ctrl_d.wait_phystatus = 1'b1;
				if (status.data_transfer_en && !status.mask_tx_pll)
					state_d = SPEED_CHANGE_DONE;
			end
			SPEED_CHANGE_DONE:
			begin
				ctrl_d.wait_phystatus = 1'b1;	// fifo released, wait for pcs
				if (status.phystatus_rise)
					state_d = WAIT_RATE_CHANGE;
			end
			default:
			begin
				state_d = WAIT_RATE_CHANGE;
			end
		endcase
	end

	// control outputs lag the state by one cycle
	always_ff @(posedge rx_clock_asn_pma_hclk)
	begin
		if (!rx_reset_asn_pma_hclk_rst_n)
		begin
			ctrl.fifo_hold      <= 1'b0;
			ctrl.dll_lock_en    <= ASN_RST_DLL_LOCK_EN;
			ctrl.wait_sw_done   <= 1'b0;
			ctrl.wait_phystatus <= 1'b0;
		end
		else
		begin
			ctrl <= ctrl_d;
		end
	end

	assign idle = (state_q == WAIT_RATE_CHANGE);

endmodule

// File: logic/asn_bond_dist.sv
// fifo_hold bonding: dft override, up/down chain distribution, master select
module asn_bond_dist
(
	input	logic			fifo_hold,
	input	asn_pkg::bond_cfg_t	bond_cfg,
	input	logic			bond_rx_asn_us_in_fifo_hold,
	input	logic			bond_rx_asn_ds_in_fifo_hold,
	output	logic			bond_rx_asn_us_out_fifo_hold,
	output	logic			bond_rx_asn_ds_out_fifo_hold,
	output	logic			rx_asn_fifo_hold
);

	logic	us_in_eff;
	logic	ds_in_eff;
	logic	up_tap;		// hold seen from the channel above
	logic	down_tap;	// hold seen from the channel below

	assign us_in_eff = bond_cfg.dft_in_en ? bond_cfg.dft_in_value : bond_rx_asn_us_in_fifo_hold;
	assign ds_in_eff = bond_cfg.dft_in_en ? bond_cfg.dft_in_value : bond_rx_asn_ds_in_fifo_hold;

	// master lane sources the chain, others pass it through
	assign bond_rx_asn_us_out_fifo_hold = bond_cfg.dist_master_sel ? fifo_hold : ds_in_eff;
	assign bond_rx_asn_ds_out_fifo_hold = bond_cfg.dist_master_sel ? fifo_hold : us_in_eff;
	assign up_tap   = bond_cfg.dist_master_sel ? fifo_hold : us_in_eff;
	assign down_tap = bond_cfg.dist_master_sel ? fifo_hold : ds_in_eff;

	always_comb
	begin
		case (bond_cfg.master_sel)
			2'b01:		rx_asn_fifo_hold = up_tap;
			2'b10:		rx_asn_fifo_hold = down_tap;
			default:	rx_asn_fifo_hold = fifo_hold;	// 00 and 11 local
		endcase
	end

endmodule

// File: logic/rx_datapath_asn.sv
// rx speed negotiation top: submodule wiring, freeze override on the fabric
// dll lock enable and the registered rate change in progress flag
module rx_datapath_asn
(
	input	logic			rx_clock_asn_pma_hclk,
	input	logic			rx_reset_asn_pma_hclk_rst_n,
	input	asn_pkg::asn_rate_t	rx_pld_rate,
	input	logic			rx_fsr_mask_tx_pll,
	input	logic [1:0]		rx_ssr_pcie_sw_done,
	input	logic			rx_hrdrst_asn_data_transfer_en,
	input	logic			pld_fabric_rx_asn_data_transfer_en,
	input	logic			rx_asn_phystatus,
	input	logic			nfrzdrv_in,
	input	logic			pr_channel_freeze_n,
	input	asn_pkg::asn_cfg_t	cfg,
	input	asn_pkg::bond_cfg_t	bond_cfg,
	input	logic			bond_rx_asn_us_in_fifo_hold,
	input	logic			bond_rx_asn_ds_in_fifo_hold,
	output	logic			bond_rx_asn_us_out_fifo_hold,
	output	logic			bond_rx_asn_ds_out_fifo_hold,
	output	logic			rx_asn_fifo_hold,
	output	logic			rx_asn_dll_lock_en,
	output	logic			pld_fabric_asn_dll_lock_en,
	output	logic			rx_asn_rate_change_in_progress
);
	import asn_pkg::*;

	logic		rate_change_pulse;
	logic		idle;
	logic		cnt_done;
	logic		frz_force;	// either freeze input active
	asn_cnt_sel_e	cnt_sel;
	asn_status_t	status;
	asn_ctrl_t	ctrl;

	asn_rate_detect u_rate_detect
	(
		.rx_clock_asn_pma_hclk		(rx_clock_asn_pma_hclk),
		.rx_reset_asn_pma_hclk_rst_n	(rx_reset_asn_pma_hclk_rst_n),
		.rx_pld_rate			(rx_pld_rate),
		.idle				(idle),
		.rate_change_pulse		(rate_change_pulse)
	);

	asn_pma_status u_pma_status
	(
		.rx_clock_asn_pma_hclk			(rx_clock_asn_pma_hclk),
		.rx_reset_asn_pma_hclk_rst_n		(rx_reset_asn_pma_hclk_rst_n),
		.rx_ssr_pcie_sw_done			(rx_ssr_pcie_sw_done),
		.rx_fsr_mask_tx_pll			(rx_fsr_mask_tx_pll),
		.rx_hrdrst_asn_data_transfer_en		(rx_hrdrst_asn_data_transfer_en),
		.pld_fabric_rx_asn_data_transfer_en	(pld_fabric_rx_asn_data_transfer_en),
		.rx_asn_phystatus			(rx_asn_phystatus),
		.hrdrst_user_ctl_en			(cfg.hrdrst_user_ctl_en),
		.ctrl					(ctrl),
		.status					(status)
	);

	asn_wait_counter u_wait_counter
	(
		.rx_clock_asn_pma_hclk		(rx_clock_asn_pma_hclk),
		.rx_reset_asn_pma_hclk_rst_n	(rx_reset_asn_pma_hclk_rst_n),
		.cnt_sel			(cnt_sel),
		.cfg				(cfg),
		.cnt_done			(cnt_done)
	);

	asn_ctrl_fsm u_ctrl_fsm
	(
		.rx_clock_asn_pma_hclk		(rx_clock_asn_pma_hclk),
		.rx_reset_asn_pma_hclk_rst_n	(rx_reset_asn_pma_hclk_rst_n),
		.cfg				(cfg),
		.rate_change_pulse		(rate_change_pulse),
		.status				(status),
		.cnt_done			(cnt_done),
		.idle				(idle),
		.cnt_sel			(cnt_sel),
		.ctrl				(ctrl)
	);

	asn_bond_dist u_bond_dist
	(
		.fifo_hold			(ctrl.fifo_hold),
		.bond_cfg			(bond_cfg),
		.bond_rx_asn_us_in_fifo_hold	(bond_rx_asn_us_in_fifo_hold),
		.bond_rx_asn_ds_in_fifo_hold	(bond_rx_asn_ds_in_fifo_hold),
		.bond_rx_asn_us_out_fifo_hold	(bond_rx_asn_us_out_fifo_hold),
		.bond_rx_asn_ds_out_fifo_hold	(bond_rx_asn_ds_out_fifo_hold),
		.rx_asn_fifo_hold		(rx_asn_fifo_hold)
	);

	// **************************************************
	// fabric side outputs
	// **************************************************
	assign rx_asn_dll_lock_en = ctrl.dll_lock_en;
	assign frz_force          = !(nfrzdrv_in && pr_channel_freeze_n);
	assign pld_fabric_asn_dll_lock_en = frz_force ? ASN_RST_DLL_LOCK_EN : rx_asn_dll_lock_en;

	// busy flag, one cycle behind the state
	always_ff @(posedge rx_clock_asn_pma_hclk)
	begin
		if (!rx_reset_asn_pma_hclk_rst_n)
			rx_asn_rate_change_in_progress <= 1'b0;
		else
			rx_asn_rate_change_in_progress <= !idle;
	end

endmodule

// File: sim/rx_datapath_asn_tb.sv
// testbench for the rx speed negotiation top
// lfsr stimulus, bonding reference model, compare monitor and directed tests
module rx_datapath_asn_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import asn_pkg::*;

	typedef enum logic [1:0] {SIG_BUSY, SIG_HOLD, SIG_DLL} probe_e;	// waitable outputs

	logic			rx_clock_asn_pma_hclk;
	logic			rx_reset_asn_pma_hclk_rst_n;
	asn_rate_t		rx_pld_rate;
	logic			rx_fsr_mask_tx_pll;
	logic [1:0]		rx_ssr_pcie_sw_done;
	logic			rx_hrdrst_asn_data_transfer_en;
	logic			pld_fabric_rx_asn_data_transfer_en;
	logic			rx_asn_phystatus;
	logic			nfrzdrv_in;
	logic			pr_channel_freeze_n;
	asn_cfg_t		cfg;
	bond_cfg_t		bond_cfg;
	logic			bond_rx_asn_us_in_fifo_hold;
	logic			bond_rx_asn_ds_in_fifo_hold;
	logic			bond_rx_asn_us_out_fifo_hold;
	logic			bond_rx_asn_ds_out_fifo_hold;
	logic			rx_asn_fifo_hold;
	logic			rx_asn_dll_lock_en;
	logic			pld_fabric_asn_dll_lock_en;
	logic			rx_asn_rate_change_in_progress;

	int		errors;
	int		checks;
	int		test_start;	// error count when the test began
	int		cyc;
	logic [31:0]	lfsr;
	logic [7:0]	rnd;
	logic		seen_busy;
	logic		bond_chk = 1'b0;	// monitor enable
	logic		bond_local = 1'b0;	// known local fifo_hold

	rx_datapath_asn uut (.*);

	initial
	begin
		rx_clock_asn_pma_hclk = 1'b0;
		forever #5 rx_clock_asn_pma_hclk = ~rx_clock_asn_pma_hclk;	// 100 MHz
	end

	// **************************************************
	// helpers
	// **************************************************
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);	// galois, right shift
	endfunction

	// expected {fifo_hold, us_out, ds_out} of the bonding logic
	function automatic logic [2:0] bond_ref(input bond_cfg_t bc, input logic us_in,
						input logic ds_in, input logic hold);
		logic	us_e;
		logic	ds_e;
		logic	sel;
		us_e = bc.dft_in_en ? bc.dft_in_value : us_in;
		ds_e = bc.dft_in_en ? bc.dft_in_value : ds_in;
		case (bc.master_sel)
			2'b01:		sel = bc.dist_master_sel ? hold : us_e;	// up tap
			2'b10:		sel = bc.dist_master_sel ? hold : ds_e;	// down tap
			default:	sel = hold;
		endcase
		if (bc.dist_master_sel)
			return {sel, hold, hold};	// master drives both directions
		return {sel, ds_e, us_e};
	endfunction

	function automatic logic probe(input probe_e sel);
		case (sel)
			SIG_BUSY:	return rx_asn_rate_change_in_progress;
			SIG_HOLD:	return rx_asn_fifo_hold;
			default:	return rx_asn_dll_lock_en;
		endcase
	endfunction

	// drives land 1 ns after the edge, outputs read there too
	task automatic step();
		@(posedge rx_clock_asn_pma_hclk);
		#1;
	endtask

	task automatic get_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v    = {v[6:0], lfsr[0]};	// one step per bit
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] expv, input logic [31:0] actv);
		checks++;
		if (expv !== actv)
		begin
			errors++;
			$display("[FAIL] %s expected %0h actual %0h", name, expv, actv);
		end
	endtask

	task automatic wait_level(input probe_e sel, input logic val, input string what,
				  output int cycles);
		cycles = 0;
		while ((probe(sel) !== val) && (cycles < 2000))
		begin
			step();
			cycles++;
		end
		if (probe(sel) !== val)
		begin
			errors++;
			$display("timeout: %s not seen within 2000 cycles", what);
		end
	endtask

	task automatic report_test(input string name);
		if (errors == test_start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - test_start);
		test_start = errors;
	endtask

	// from WAIT_SWITCH_REQUEST to idle; dte source follows cfg
	task automatic complete_negotiation(input string name);
		rx_fsr_mask_tx_pll = 1'b1;
		wait_level(SIG_DLL, 1'b1, "dll lock enable return", cyc);
		check_val({name, " hold at relock"}, 32'(1), 32'(rx_asn_fifo_hold));
		rx_fsr_mask_tx_pll = 1'b0;
		if (cfg.hrdrst_user_ctl_en)
			pld_fabric_rx_asn_data_transfer_en = 1'b1;
		else
			rx_hrdrst_asn_data_transfer_en = 1'b1;
		wait_level(SIG_HOLD, 1'b0, "fifo hold release", cyc);
		repeat (4) step();	// still busy until phystatus
		check_val({name, " busy until phystatus"}, 32'(1),
			  32'(rx_asn_rate_change_in_progress));
		rx_asn_phystatus = 1'b1;
		repeat (3) step();
		rx_asn_phystatus = 1'b0;
		wait_level(SIG_BUSY, 1'b0, "end of negotiation", cyc);
		rx_hrdrst_asn_data_transfer_en     = 1'b0;
		pld_fabric_rx_asn_data_transfer_en = 1'b0;
	endtask

	task automatic bond_sweep(input logic hold);
		bond_local = hold;
		bond_chk   = 1'b1;
		repeat (64)
		begin
			get_bits(5, rnd);
			bond_cfg = bond_cfg_t'(rnd[4:0]);
			get_bits(2, rnd);
			bond_rx_asn_us_in_fifo_hold = rnd[1];
			bond_rx_asn_ds_in_fifo_hold = rnd[0];
			step();
		end
		bond_chk = 1'b0;
		bond_cfg = '{master_sel:2'b00, dist_master_sel:1'b1, dft_in_en:1'b0, dft_in_value:1'b0};
	endtask

	// compare at the falling edge, bonding paths are combinational
	always @(negedge rx_clock_asn_pma_hclk)
	begin
		if (bond_chk)
			check_val("bonding", 32'(bond_ref(bond_cfg, bond_rx_asn_us_in_fifo_hold,
				  bond_rx_asn_ds_in_fifo_hold, bond_local)),
				  32'({rx_asn_fifo_hold, bond_rx_asn_us_out_fifo_hold,
				  bond_rx_asn_ds_out_fifo_hold}));
	end

	// **************************************************
	// tests
	// **************************************************
	initial
	begin
		errors = 0;
		checks = 0;
		test_start = 0;
		lfsr = 32'd97218;
		rx_reset_asn_pma_hclk_rst_n = 1'b0;
		rx_pld_rate = 2'd0;
		rx_fsr_mask_tx_pll = 1'b0;
		rx_ssr_pcie_sw_done = 2'b00;
		rx_hrdrst_asn_data_transfer_en = 1'b0;
		pld_fabric_rx_asn_data_transfer_en = 1'b0;
		rx_asn_phystatus = 1'b0;
		nfrzdrv_in = 1'b1;
		pr_channel_freeze_n = 1'b1;
		cfg = '{asn_en:1'b1, bypass_sw_done:1'b0, hrdrst_user_ctl_en:1'b0,
			fifo_flush_cnt:8'd12, dll_reset_cnt:8'd6, sw_done_cnt:8'd5};
		bond_cfg = '{master_sel:2'b00, dist_master_sel:1'b1, dft_in_en:1'b0, dft_in_value:1'b0};
		bond_rx_asn_us_in_fifo_hold = 1'b0;
		bond_rx_asn_ds_in_fifo_hold = 1'b0;
		repeat (16) step();
		rx_reset_asn_pma_hclk_rst_n = 1'b1;
		step();

		// reset values
		check_val("reset busy", 32'(0), 32'(rx_asn_rate_change_in_progress));
		check_val("reset hold", 32'(0), 32'(rx_asn_fifo_hold));
		check_val("reset dll", 32'(1), 32'(rx_asn_dll_lock_en));
		check_val("reset bond out", 32'(0),
			  32'({bond_rx_asn_us_out_fifo_hold, bond_rx_asn_ds_out_fifo_hold}));
		check_val("reset fabric dll", 32'(1), 32'(pld_fabric_asn_dll_lock_en));
		report_test("reset");

		// full sequence, hard reset dte source, sw_done toggle
		rx_pld_rate = 2'd1;
		wait_level(SIG_BUSY, 1'b1, "in progress rise", cyc);
		check_val("full hold rise", 32'(1), 32'(rx_asn_fifo_hold));
		wait_level(SIG_DLL, 1'b0, "dll lock enable drop", cyc);
		check_val("full flush time", 32'(1), 32'(cyc >= int'(cfg.fifo_flush_cnt)));
		check_val("full fabric dll", 32'(0), 32'(pld_fabric_asn_dll_lock_en));
		nfrzdrv_in = 1'b0;	// either freeze forces fabric dll lock enable
		step();
		check_val("full drv freeze", 32'(1), 32'(pld_fabric_asn_dll_lock_en));
		nfrzdrv_in = 1'b1;
		pr_channel_freeze_n = 1'b0;
		step();
		check_val("full pr freeze", 32'(1), 32'(pld_fabric_asn_dll_lock_en));
		pr_channel_freeze_n = 1'b1;
		rx_ssr_pcie_sw_done = 2'b01;
		complete_negotiation("full");
		report_test("full negotiation");

		// bypass sw_done, fabric dte source
		cfg.bypass_sw_done     = 1'b1;
		cfg.hrdrst_user_ctl_en = 1'b1;
		rx_pld_rate = 2'd2;
		wait_level(SIG_BUSY, 1'b1, "in progress rise", cyc);
		wait_level(SIG_DLL, 1'b0, "dll lock enable drop", cyc);
		complete_negotiation("bypass");
		report_test("bypass and user source");

		// disabled lane ignores rate, same rate is no request
		cfg.asn_en  = 1'b0;
		rx_pld_rate = 2'd3;
		seen_busy   = 1'b0;
		repeat (200)
		begin
			step();
			seen_busy = seen_busy | rx_asn_rate_change_in_progress;
		end
		rx_pld_rate = 2'd2;
		repeat (10) step();	// held rate follows while parked
		cfg.asn_en  = 1'b1;
		step();
		rx_pld_rate = 2'd2;
		repeat (200)
		begin
			step();
			seen_busy = seen_busy | rx_asn_rate_change_in_progress;
		end
		check_val("no negotiation", 32'(0), 32'(seen_busy));
		report_test("disable and stable rate");

		// bonding while idle, then with hold up in WAIT_SWITCH_REQUEST
		bond_sweep(1'b0);
		rx_pld_rate = 2'd1;
		wait_level(SIG_DLL, 1'b0, "dll lock enable drop", cyc);
		bond_sweep(1'b1);
		bond_rx_asn_us_in_fifo_hold = 1'b0;
		bond_rx_asn_ds_in_fifo_hold = 1'b0;
		complete_negotiation("bonding");
		report_test("bonding");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: build.f
logic/asn_pkg.sv
logic/asn_bitsync.sv
logic/asn_rate_detect.sv
logic/asn_pma_status.sv
logic/asn_wait_counter.sv
logic/asn_ctrl_fsm.sv
logic/asn_bond_dist.sv
logic/rx_datapath_asn.sv
sim/rx_datapath_asn_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with verilator, run, pass only when the pass message shows up
verilator --binary -j 0 --top-module rx_datapath_asn_tb -f build.f -o rx_asn_sim \
	&& ./obj_dir/rx_asn_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
	&& echo "run_sim: pass" \
	|| { echo "run_sim: fail"; exit 1; }
